// ==== wdp_macros.svh ====
//////////////////////////////
// write-data path constants
//////////////////////////////

`ifndef WDP_MACROS_SVH
`define WDP_MACROS_SVH

// local data width and the byte enables that go with it
`define WDP_DATA_WIDTH 32
`define WDP_BE_WIDTH (`WDP_DATA_WIDTH / 8)

// 16 entries, almost full at 12 or more
`define WDP_FIFO_DEPTH_LOG2 4
`define WDP_ALMOST_FULL_MARGIN 4

// burst size field and buffered-beat counter
`define WDP_SIZE_WIDTH 6
`define WDP_BEATS_WIDTH 5

`endif

// ==== wdp_pkg.sv ====
//////////////////////////////
// write-data path types
//////////////////////////////

`include "wdp_macros.svh"

package wdp_pkg;

    // one local data beat
    typedef logic [`WDP_DATA_WIDTH-1:0] wdata_t;

    // byte enables on the local side, data mask on the memory side
    typedef logic [`WDP_BE_WIDTH-1:0] be_t;

    // burst length in beats, never zero when issued
    typedef logic [`WDP_SIZE_WIDTH-1:0] size_t;

    // beats currently held in the write-data FIFO
    typedef logic [`WDP_BEATS_WIDTH-1:0] beats_t;

endpackage

// ==== wdp_sync_fifo.sv ====
//////////////////////////////
// synchronous FIFO with registered
// read data and almost-full flag
//////////////////////////////

`include "wdp_macros.svh"

module wdp_sync_fifo #(
    parameter type payload_t = logic
) (
    input  logic     ctl_clk,
    input  logic     ctl_reset_n,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     almost_full
);

    localparam int DEPTH    = 1 << `WDP_FIFO_DEPTH_LOG2;
    localparam int AF_LEVEL = DEPTH - `WDP_ALMOST_FULL_MARGIN;

    payload_t mem [DEPTH];

    logic [`WDP_FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [`WDP_FIFO_DEPTH_LOG2-1:0] rd_ptr;
    // one extra bit so that a full buffer is distinguishable from empty
    logic [`WDP_FIFO_DEPTH_LOG2:0]   count;

    always_ff @(posedge ctl_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // read data shows up one cycle after the read strobe
    always_ff @(posedge ctl_clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge ctl_clk or negedge ctl_reset_n) begin
        if (!ctl_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // leaves room for beats already in flight when the flag rises
    assign almost_full = (int'(count) >= AF_LEVEL);

endmodule

// ==== wdp_wdata_fifo.sv ====
//////////////////////////////
// write-data FIFO, data and byte
// enables paired, beats counted
//////////////////////////////

module wdp_wdata_fifo (
    input  logic            ctl_clk,
    input  logic            ctl_reset_n,
    input  logic            write_req_to_wfifo,
    input  wdp_pkg::wdata_t wdata_to_wfifo,
    input  wdp_pkg::be_t    be_to_wfifo,
    input  logic            wdata_fifo_read,
    output logic            wdata_fifo_full,
    output wdp_pkg::wdata_t wdata_fifo_wdata,
    output wdp_pkg::be_t    wdata_fifo_be,
    output wdp_pkg::beats_t beats_in_wfifo
);

    // both FIFOs see the same strobes so each beat keeps its byte enables
    wdp_sync_fifo #(.payload_t(wdp_pkg::wdata_t)) u_data_fifo (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .wr_en       (write_req_to_wfifo),
        .wr_data     (wdata_to_wfifo),
        .rd_en       (wdata_fifo_read),
        .rd_data     (wdata_fifo_wdata),
        .almost_full (wdata_fifo_full)
    );

    // occupancy matches the data FIFO, so its flag is not needed
    wdp_sync_fifo #(.payload_t(wdp_pkg::be_t)) u_be_fifo (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .wr_en       (write_req_to_wfifo),
        .wr_data     (be_to_wfifo),
        .rd_en       (wdata_fifo_read),
        .rd_data     (wdata_fifo_be),
        .almost_full ()
    );

    always_ff @(posedge ctl_clk or negedge ctl_reset_n) begin
        if (!ctl_reset_n) begin
            beats_in_wfifo <= '0;
        end else if (write_req_to_wfifo && !wdata_fifo_read) begin
            beats_in_wfifo <= beats_in_wfifo + 1'b1;
        end else if (wdata_fifo_read && !write_req_to_wfifo) begin
            beats_in_wfifo <= beats_in_wfifo - 1'b1;
        end
    end

endmodule

// ==== wdp_local_wr_ctrl.sv ====
//////////////////////////////
// local write side, accepts beats
// and checks burst framing
//////////////////////////////

module wdp_local_wr_ctrl (
    input  logic            ctl_clk,
    input  logic            ctl_reset_n,
    input  logic            local_write_req,
    input  logic            local_burstbegin,
    input  wdp_pkg::size_t  local_size,
    input  wdp_pkg::wdata_t local_wdata,
    input  wdp_pkg::be_t    local_be,
    input  logic            wdata_fifo_full,
    output logic            local_ready,
    output logic            local_burst_err,
    output logic            write_req_to_wfifo,
    output wdp_pkg::wdata_t wdata_to_wfifo,
    output wdp_pkg::be_t    be_to_wfifo
);

    wdp_pkg::size_t beats_left;
    logic           accept;

    assign local_ready = !wdata_fifo_full;
    assign accept      = local_write_req && local_ready;

    // accepted beats go straight into the FIFO
    assign write_req_to_wfifo = accept;
    assign wdata_to_wfifo     = local_wdata;
    assign be_to_wfifo        = local_be;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n) begin
        if (!ctl_reset_n) begin
            beats_left      <= '0;
            local_burst_err <= 1'b0;
        end else if (accept) begin
            if (local_burstbegin) begin
                // a new burst restarts the count even if the old one was cut short
                beats_left <= local_size - 1'b1;
                if (beats_left != '0) begin
                    local_burst_err <= 1'b1;
                end
            end else if (beats_left != '0) begin
                beats_left <= beats_left - 1'b1;
            end else begin
                // beat outside any burst
                local_burst_err <= 1'b1;
            end
        end
    end

endmodule

// ==== wdp_afi_wdata.sv ====
//////////////////////////////
// memory-side write data, serves
// commands from the write FIFO
//////////////////////////////

module wdp_afi_wdata (
    input  logic            ctl_clk,
    input  logic            ctl_reset_n,
    input  logic            wr_cmd_valid,
    input  wdp_pkg::size_t  wr_cmd_size,
    input  wdp_pkg::beats_t beats_in_wfifo,
    input  wdp_pkg::wdata_t wdata_fifo_wdata,
    input  wdp_pkg::be_t    wdata_fifo_be,
    output logic            wr_cmd_ready,
    output logic            wdata_fifo_read,
    output wdp_pkg::wdata_t afi_wdata,
    output wdp_pkg::be_t    afi_dm,
    output logic            afi_wdata_valid,
    output logic            wr_burst_done
);

    wdp_pkg::size_t reads_left;
    logic           last_read;

    assign wr_cmd_ready = (reads_left == '0);

    // one read per cycle, stalled whenever the FIFO runs dry
    assign wdata_fifo_read = (reads_left != '0) && (beats_in_wfifo != '0);

    assign last_read = wdata_fifo_read && (reads_left == wdp_pkg::size_t'(1));

    always_ff @(posedge ctl_clk or negedge ctl_reset_n) begin
        if (!ctl_reset_n) begin
            reads_left <= '0;
        end else if (wr_cmd_valid && wr_cmd_ready) begin
            reads_left <= wr_cmd_size;
        end else if (wdata_fifo_read) begin
            reads_left <= reads_left - 1'b1;
        end
    end

    // FIFO data lags the read by one cycle, so the strobes are delayed to match
    always_ff @(posedge ctl_clk or negedge ctl_reset_n) begin
        if (!ctl_reset_n) begin
            afi_wdata_valid <= 1'b0;
            wr_burst_done   <= 1'b0;
        end else begin
            afi_wdata_valid <= wdata_fifo_read;
            wr_burst_done   <= last_read;
        end
    end

    assign afi_wdata = wdata_fifo_wdata;

    // a set mask bit blocks that byte on the memory side
    assign afi_dm = ~wdata_fifo_be;

endmodule

// ==== wdp_top.sv ====
//////////////////////////////
// write-data path top level
//////////////////////////////

module wdp_top (
    input  logic            ctl_clk,
    input  logic            ctl_reset_n,
    input  logic            local_write_req,
    input  logic            local_burstbegin,
    input  wdp_pkg::size_t  local_size,
    input  wdp_pkg::wdata_t local_wdata,
    input  wdp_pkg::be_t    local_be,
    output logic            local_ready,
    output logic            local_burst_err,
    input  logic            wr_cmd_valid,
    input  wdp_pkg::size_t  wr_cmd_size,
    output logic            wr_cmd_ready,
    output wdp_pkg::wdata_t afi_wdata,
    output wdp_pkg::be_t    afi_dm,
    output logic            afi_wdata_valid,
    output logic            wr_burst_done
);

    logic            write_req_to_wfifo;
    wdp_pkg::wdata_t wdata_to_wfifo;
    wdp_pkg::be_t    be_to_wfifo;
    logic            wdata_fifo_full;
    logic            wdata_fifo_read;
    wdp_pkg::wdata_t wdata_fifo_wdata;
    wdp_pkg::be_t    wdata_fifo_be;
    wdp_pkg::beats_t beats_in_wfifo;

    wdp_local_wr_ctrl u_local_wr_ctrl (
        .ctl_clk            (ctl_clk),
        .ctl_reset_n        (ctl_reset_n),
        .local_write_req    (local_write_req),
        .local_burstbegin   (local_burstbegin),
        .local_size         (local_size),
        .local_wdata        (local_wdata),
        .local_be           (local_be),
        .wdata_fifo_full    (wdata_fifo_full),
        .local_ready        (local_ready),
        .local_burst_err    (local_burst_err),
        .write_req_to_wfifo (write_req_to_wfifo),
        .wdata_to_wfifo     (wdata_to_wfifo),
        .be_to_wfifo        (be_to_wfifo)
    );

    wdp_wdata_fifo u_wdata_fifo (
        .ctl_clk            (ctl_clk),
        .ctl_reset_n        (ctl_reset_n),
        .write_req_to_wfifo (write_req_to_wfifo),
        .wdata_to_wfifo     (wdata_to_wfifo),
        .be_to_wfifo        (be_to_wfifo),
        .wdata_fifo_read    (wdata_fifo_read),
        .wdata_fifo_full    (wdata_fifo_full),
        .wdata_fifo_wdata   (wdata_fifo_wdata),
        .wdata_fifo_be      (wdata_fifo_be),
        .beats_in_wfifo     (beats_in_wfifo)
    );

    wdp_afi_wdata u_afi_wdata (
        .ctl_clk            (ctl_clk),
        .ctl_reset_n        (ctl_reset_n),
        .wr_cmd_valid       (wr_cmd_valid),
        .wr_cmd_size        (wr_cmd_size),
        .beats_in_wfifo     (beats_in_wfifo),
        .wdata_fifo_wdata   (wdata_fifo_wdata),
        .wdata_fifo_be      (wdata_fifo_be),
        .wr_cmd_ready       (wr_cmd_ready),
        .wdata_fifo_read    (wdata_fifo_read),
        .afi_wdata          (afi_wdata),
        .afi_dm             (afi_dm),
        .afi_wdata_valid    (afi_wdata_valid),
        .wr_burst_done      (wr_burst_done)
    );

endmodule

// ==== wdp_tb_assertions.sv ====
//////////////////////////////
// write-data path protocol checks
//////////////////////////////

module wdp_tb_assertions (
    input logic            ctl_clk,
    input logic            ctl_reset_n,
    input logic            wr_cmd_valid,
    input logic            wr_cmd_ready,
    input logic            wdata_fifo_read,
    input wdp_pkg::beats_t beats_in_wfifo,
    input logic            afi_wdata_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // the scheduler may only pulse a command while the output side is idle
    a_cmd_when_ready: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        wr_cmd_valid |-> wr_cmd_ready)
        else $error("write command issued while wr_cmd_ready was low");

    a_read_not_empty: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        wdata_fifo_read |-> (beats_in_wfifo != '0))
        else $error("write-data FIFO read while no beats were buffered");

    // every read gives exactly one valid beat on the following cycle
    a_valid_after_read: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        wdata_fifo_read |=> afi_wdata_valid)
        else $error("afi_wdata_valid missing one cycle after a FIFO read");

endmodule

bind wdp_top wdp_tb_assertions u_assertions (
    .ctl_clk         (ctl_clk),
    .ctl_reset_n     (ctl_reset_n),
    .wr_cmd_valid    (wr_cmd_valid),
    .wr_cmd_ready    (wr_cmd_ready),
    .wdata_fifo_read (wdata_fifo_read),
    .beats_in_wfifo  (beats_in_wfifo),
    .afi_wdata_valid (afi_wdata_valid)
);

// ==== wdp_tb.sv ====
//////////////////////////////
// directed testbench for the
// write-data path
//////////////////////////////

module wdp_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          TIMEOUT = 50;
    localparam int unsigned SEED    = 32'h123ac87a;

    logic            ctl_clk;
    logic            ctl_reset_n;
    logic            local_write_req;
    logic            local_burstbegin;
    wdp_pkg::size_t  local_size;
    wdp_pkg::wdata_t local_wdata;
    wdp_pkg::be_t    local_be;
    logic            local_ready;
    logic            local_burst_err;
    logic            wr_cmd_valid;
    wdp_pkg::size_t  wr_cmd_size;
    logic            wr_cmd_ready;
    wdp_pkg::wdata_t afi_wdata;
    wdp_pkg::be_t    afi_dm;
    logic            afi_wdata_valid;
    logic            wr_burst_done;

    // beats accepted on the local side, in the order they must leave
    wdp_pkg::wdata_t wdata_q[$];
    wdp_pkg::be_t    be_q[$];
    string           test_name;

    wdp_top DUT (
        .ctl_clk          (ctl_clk),
        .ctl_reset_n      (ctl_reset_n),
        .local_write_req  (local_write_req),
        .local_burstbegin (local_burstbegin),
        .local_size       (local_size),
        .local_wdata      (local_wdata),
        .local_be         (local_be),
        .local_ready      (local_ready),
        .local_burst_err  (local_burst_err),
        .wr_cmd_valid     (wr_cmd_valid),
        .wr_cmd_size      (wr_cmd_size),
        .wr_cmd_ready     (wr_cmd_ready),
        .afi_wdata        (afi_wdata),
        .afi_dm           (afi_dm),
        .afi_wdata_valid  (afi_wdata_valid),
        .wr_burst_done    (wr_burst_done)
    );

    always #2 ctl_clk = ~ctl_clk;

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_wdata(input string what, input wdp_pkg::wdata_t exp,
                               input wdp_pkg::wdata_t act);
        if (act !== exp) begin
            $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_dm(input string what, input wdp_pkg::be_t exp,
                            input wdp_pkg::be_t act);
        if (act !== exp) begin
            $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s %s expected %b actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    // all driving and sampling happens 1 ns after the rising edge
    task automatic tick();
        @(posedge ctl_clk);
        #1;
    endtask

    task automatic apply_reset();
        ctl_reset_n = 1'b0;
        repeat (2) @(posedge ctl_clk);
        #1;
        ctl_reset_n = 1'b1;
        wdata_q.delete();
        be_q.delete();
    endtask

    task automatic write_burst(input wdp_pkg::size_t n);
        int total;
        int i;
        total = int'(n);
        for (i = 0; i < total; i++) begin
            check_flag("local_ready", 1'b1, local_ready);
            local_write_req  = 1'b1;
            local_burstbegin = (i == 0);
            local_size       = n;
            local_wdata      = $urandom;
            local_be         = wdp_pkg::be_t'($urandom);
            wdata_q.push_back(local_wdata);
            be_q.push_back(local_be);
            tick();
        end
        local_write_req  = 1'b0;
        local_burstbegin = 1'b0;
    endtask

    task automatic issue_cmd(input wdp_pkg::size_t n);
        int waited;
        waited = 0;
        while (wr_cmd_ready !== 1'b1) begin
            if (waited == TIMEOUT) begin
                $display("timeout waiting for wr_cmd_ready in %s", test_name);
                abort_run();
            end
            tick();
            waited++;
        end
        wr_cmd_valid = 1'b1;
        wr_cmd_size  = n;
        tick();
        wr_cmd_valid = 1'b0;
    endtask

    task automatic expect_beats(input wdp_pkg::size_t n);
        int              total;
        int              i;
        int              waited;
        wdp_pkg::wdata_t exp_data;
        wdp_pkg::be_t    exp_be;
        total = int'(n);
        for (i = 0; i < total; i++) begin
            waited = 0;
            tick();
            while (afi_wdata_valid !== 1'b1) begin
                check_flag("wr_burst_done between beats", 1'b0, wr_burst_done);
                if (waited == TIMEOUT) begin
                    $display("timeout waiting for write data beat %0d in %s", i, test_name);
                    abort_run();
                end
                tick();
                waited++;
            end
            if (wdata_q.size() == 0) begin
                $display("write data appeared in %s with no beat left to send", test_name);
                abort_run();
            end
            exp_data = wdata_q.pop_front();
            exp_be   = be_q.pop_front();
            check_wdata("afi_wdata", exp_data, afi_wdata);
            check_dm("afi_dm", ~exp_be, afi_dm);
            check_flag("wr_burst_done", (i == total - 1), wr_burst_done);
        end
        check_flag("wr_cmd_ready after last beat", 1'b1, wr_cmd_ready);
    endtask

    task automatic test_reset_state();
        test_name = "reset_state";
        check_flag("local_ready", 1'b1, local_ready);
        check_flag("wr_cmd_ready", 1'b1, wr_cmd_ready);
        check_flag("afi_wdata_valid", 1'b0, afi_wdata_valid);
        check_flag("local_burst_err", 1'b0, local_burst_err);
        check_flag("wr_burst_done", 1'b0, wr_burst_done);
    endtask

    task automatic test_single_burst();
        test_name = "single_burst";
        write_burst(6'd4);
        issue_cmd(6'd4);
        expect_beats(6'd4);
    endtask

    task automatic test_cmd_before_data();
        test_name = "cmd_before_data";
        issue_cmd(6'd4);
        repeat (6) begin
            check_flag("afi_wdata_valid while empty", 1'b0, afi_wdata_valid);
            check_flag("wr_cmd_ready while waiting", 1'b0, wr_cmd_ready);
            tick();
        end
        // the command is already open, so beats leave while the burst is written
        fork
            write_burst(6'd4);
            expect_beats(6'd4);
        join
    endtask

    task automatic test_fill_and_drain();
        test_name = "fill_and_drain";
        write_burst(6'd12);
        repeat (2) begin
            check_flag("local_ready at almost full", 1'b0, local_ready);
            local_write_req = 1'b1;
            local_wdata     = $urandom;
            local_be        = wdp_pkg::be_t'($urandom);
            tick();
        end
        local_write_req = 1'b0;
        issue_cmd(6'd12);
        expect_beats(6'd12);
        check_flag("local_ready after drain", 1'b1, local_ready);
    endtask

    task automatic test_streaming();
        test_name = "streaming";
        fork
            write_burst(6'd8);
            begin
                tick();
                tick();
                issue_cmd(6'd8);
                expect_beats(6'd8);
            end
        join
    endtask

    task automatic test_burst_error();
        test_name = "burst_error";
        check_flag("local_burst_err before", 1'b0, local_burst_err);
        local_write_req  = 1'b1;
        local_burstbegin = 1'b1;
        local_size       = 6'd4;
        local_wdata      = $urandom;
        local_be         = wdp_pkg::be_t'($urandom);
        tick();
        // second burstbegin while three beats are still owed
        local_wdata = $urandom;
        tick();
        local_write_req  = 1'b0;
        local_burstbegin = 1'b0;
        check_flag("local_burst_err set", 1'b1, local_burst_err);
        repeat (4) begin
            tick();
            check_flag("local_burst_err held", 1'b1, local_burst_err);
        end
        apply_reset();
        check_flag("local_burst_err after reset", 1'b0, local_burst_err);
    endtask

    initial begin
        ctl_clk          = 1'b0;
        ctl_reset_n      = 1'b0;
        local_write_req  = 1'b0;
        local_burstbegin = 1'b0;
        local_size       = '0;
        local_wdata      = '0;
        local_be         = '0;
        wr_cmd_valid     = 1'b0;
        wr_cmd_size      = '0;
        test_name        = "init";
        void'($urandom(SEED));
        apply_reset();
        test_reset_state();
        test_single_burst();
        test_cmd_before_data();
        test_fill_and_drain();
        test_streaming();
        test_burst_error();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
wdp_pkg.sv
wdp_sync_fifo.sv
wdp_wdata_fifo.sv
wdp_local_wr_ctrl.sv
wdp_afi_wdata.sv
wdp_top.sv
wdp_tb_assertions.sv
wdp_tb.sv

// ==== Makefile ====
SIM        = verilator
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/1ps
TOP        = wdp_tb
FILELIST   = list.f
OBJDIR     = obj_dir

.PHONY: lint sim clean

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
